// ==== hw/mapper_pkg.sv ====
package mapper_pkg;

    // one byte of the console data bus
    typedef logic [7:0] byte_t;

    // full bank number as seen by the 2003 register layout
    typedef logic [9:0] bank_t;

    // bank number after window selection, before masking
    typedef logic [8:0] rom_bank_t;

    // linear window offset register
    typedef logic [7:0] linear_t;

    // nileswan bank masks
    typedef logic [8:0] rom_mask_t;
    typedef logic [3:0] ram_mask_t;

    // i/o register address, addr_hi above addr_lo[3:0]
    typedef logic [7:0] io_addr_t;

    // upper memory address lines driven to psram and sram
    typedef logic [6:0] ext_addr_t;

    // 64 KiB window picked by addr_hi
    typedef enum logic [2:0] {
        area_none,
        area_ram,
        area_rom0,
        area_rom1,
        area_linear
    } area_t;

endpackage

// ==== hw/reg_map_pkg.sv ====
package reg_map_pkg;

    import mapper_pkg::*;

    // 2001 layout, 8-bit bank registers
    localparam io_addr_t reg_linear_off = 8'hC0;
    localparam io_addr_t reg_ram_bank = 8'hC1;
    localparam io_addr_t reg_rom_bank_0 = 8'hC2;
    localparam io_addr_t reg_rom_bank_1 = 8'hC3;

    // 2003 layout, banks split into low byte and bits 9:8
    localparam io_addr_t reg_mem_ctrl = 8'hCE;
    localparam io_addr_t reg_ram_bank_l = 8'hD0;
    localparam io_addr_t reg_ram_bank_h = 8'hD1;
    localparam io_addr_t reg_rom_bank_0_l = 8'hD2;
    localparam io_addr_t reg_rom_bank_0_h = 8'hD3;
    localparam io_addr_t reg_rom_bank_1_l = 8'hD4;
    localparam io_addr_t reg_rom_bank_1_h = 8'hD5;

    // nileswan extension
    localparam io_addr_t reg_pow_cnt = 8'hE2;
    localparam io_addr_t reg_bank_mask_lo = 8'hE4;
    localparam io_addr_t reg_bank_mask_hi = 8'hE5;

    // values loaded on reset
    localparam bank_t rst_bank = 10'h3FF;
    localparam linear_t rst_linear = 8'hFF;
    localparam rom_mask_t rst_rom_mask = 9'h1FF;
    localparam ram_mask_t rst_ram_mask = 4'hF;
    localparam logic rst_apply = 1'b1;
    localparam logic rst_self_flash = 1'b0;
    localparam logic rst_sram_enable = 1'b1;

    // POW_CNT layout
    localparam int pow_sram_bit = 6;
    // bits 2..4 report the nileswan, 2001 and 2003 extensions as present
    localparam byte_t pow_fixed_bits = 8'h1C;

endpackage

// ==== hw/bank_cfg_if.sv ====
`timescale 1ns/1ps

interface bank_cfg_if
    import mapper_pkg::*;
();

    // bank registers
    bank_t ram_bank;
    bank_t rom0_bank;
    bank_t rom1_bank;
    linear_t linear_off;
    logic self_flash;

    // nileswan masks and where they apply
    rom_mask_t rom_mask;
    ram_mask_t ram_mask;
    logic apply_rom0;
    logic apply_rom1;
    logic apply_ram;

    // POW_CNT sram enable
    logic sram_enable;

    modport regs (
        output ram_bank, rom0_bank, rom1_bank, linear_off, self_flash,
        output rom_mask, ram_mask, apply_rom0, apply_rom1, apply_ram,
        output sram_enable
    );

    modport map (
        input ram_bank, rom0_bank, rom1_bank, linear_off, self_flash,
        input rom_mask, ram_mask, apply_rom0, apply_rom1, apply_ram,
        input sram_enable
    );

endinterface

// ==== hw/bank_regs.sv ====
`timescale 1ns/1ps

module bank_regs
    import mapper_pkg::*;
    import reg_map_pkg::*;
(
    input  logic nWE,
    input  logic reset,
    input  logic n_sel,
    input  logic n_io,
    input  logic n_oe,
    input  io_addr_t io_addr,
    input  byte_t wdata,
    output byte_t data_out,
    output logic data_oe,
    bank_cfg_if.regs cfg
);

    bank_t ram_bank;
    bank_t rom0_bank;
    bank_t rom1_bank;
    linear_t linear_off;
    logic self_flash;
    rom_mask_t rom_mask;
    ram_mask_t ram_mask;
    logic apply_rom0;
    logic apply_rom1;
    logic apply_ram;
    logic sram_enable;

    logic wr_en;
    logic rd_hit;
    byte_t rd_data;

    // bits 9:8 of a bank as the 2003 "_h" registers present them
    function automatic byte_t bank_hi(input bank_t bank);
        return {6'b0, bank[9:8]};
    endfunction

    // n_oe high keeps a read cycle from being taken as a write
    assign wr_en = ~n_sel & ~n_io & n_oe;

    always_ff @(posedge nWE) begin
        if (reset) begin
            ram_bank <= rst_bank;
            rom0_bank <= rst_bank;
            rom1_bank <= rst_bank;
            linear_off <= rst_linear;
            self_flash <= rst_self_flash;
            rom_mask <= rst_rom_mask;
            ram_mask <= rst_ram_mask;
            apply_rom0 <= rst_apply;
            apply_rom1 <= rst_apply;
            apply_ram <= rst_apply;
            sram_enable <= rst_sram_enable;
        end else if (wr_en) begin
            case (io_addr)
                reg_linear_off: linear_off <= wdata;
                // 2001 and 2003 low registers alias the same bits
                reg_ram_bank, reg_ram_bank_l: ram_bank[7:0] <= wdata;
                reg_rom_bank_0, reg_rom_bank_0_l: rom0_bank[7:0] <= wdata;
                reg_rom_bank_1, reg_rom_bank_1_l: rom1_bank[7:0] <= wdata;
                reg_ram_bank_h: ram_bank[9:8] <= wdata[1:0];
                reg_rom_bank_0_h: rom0_bank[9:8] <= wdata[1:0];
                reg_rom_bank_1_h: rom1_bank[9:8] <= wdata[1:0];
                reg_mem_ctrl: self_flash <= wdata[0];
                reg_bank_mask_lo: rom_mask[7:0] <= wdata;
                reg_bank_mask_hi: begin
                    rom_mask[8] <= wdata[0];
                    apply_rom0 <= wdata[1];
                    apply_rom1 <= wdata[2];
                    apply_ram <= wdata[3];
                    ram_mask <= wdata[7:4];
                end
                // only the sram bit of POW_CNT is kept
                reg_pow_cnt: sram_enable <= wdata[pow_sram_bit];
                default: begin
                end
            endcase
        end
    end

    // readback mux
    always_comb begin
        rd_hit = 1'b1;
        rd_data = '0;
        case (io_addr)
            reg_linear_off: rd_data = linear_off;
            reg_ram_bank, reg_ram_bank_l: rd_data = ram_bank[7:0];
            reg_rom_bank_0, reg_rom_bank_0_l: rd_data = rom0_bank[7:0];
            reg_rom_bank_1, reg_rom_bank_1_l: rd_data = rom1_bank[7:0];
            reg_ram_bank_h: rd_data = bank_hi(ram_bank);
            reg_rom_bank_0_h: rd_data = bank_hi(rom0_bank);
            reg_rom_bank_1_h: rd_data = bank_hi(rom1_bank);
            reg_mem_ctrl: rd_data = {7'b0, self_flash};
            reg_bank_mask_lo: rd_data = rom_mask[7:0];
            reg_bank_mask_hi: begin
                rd_data = {ram_mask, apply_ram, apply_rom1, apply_rom0, rom_mask[8]};
            end
            reg_pow_cnt: begin
                rd_data = pow_fixed_bits;
                rd_data[pow_sram_bit] = sram_enable;
            end
            default: rd_hit = 1'b0;
        endcase
    end

    assign data_oe = ~n_sel & ~n_io & ~n_oe & rd_hit;
    assign data_out = rd_data;

    // configuration seen by the decoder
    assign cfg.ram_bank = ram_bank;
    assign cfg.rom0_bank = rom0_bank;
    assign cfg.rom1_bank = rom1_bank;
    assign cfg.linear_off = linear_off;
    assign cfg.self_flash = self_flash;
    assign cfg.rom_mask = rom_mask;
    assign cfg.ram_mask = ram_mask;
    assign cfg.apply_rom0 = apply_rom0;
    assign cfg.apply_rom1 = apply_rom1;
    assign cfg.apply_ram = apply_ram;
    assign cfg.sram_enable = sram_enable;

endmodule

// ==== hw/bank_map.sv ====
`timescale 1ns/1ps

module bank_map
    import mapper_pkg::*;
(
    input  logic n_sel,
    input  logic n_io,
    input  logic [3:0] addr_hi,
    input  logic addr_lsb,
    bank_cfg_if.map cfg,
    output ext_addr_t addr_ext,
    output logic n_psram1_sel,
    output logic n_psram2_sel,
    output logic n_sram_sel,
    output logic psram_n_lb,
    output logic psram_n_ub
);

    area_t area;
    rom_bank_t rom_bank;
    rom_bank_t rom_masked;
    ram_mask_t ram_masked;
    logic rom_side;
    logic ram_side;
    logic apply_rom_mask;
    logic mem_access;
    logic psram1_hit;
    logic psram2_hit;
    logic sram_hit;

    // window from the top address nibble
    always_comb begin
        case (addr_hi)
            4'h0: area = area_none;
            4'h1: area = area_ram;
            4'h2: area = area_rom0;
            4'h3: area = area_rom1;
            default: area = area_linear;
        endcase
    end

    // bank selection per window
    always_comb begin
        rom_bank = '0;
        rom_side = 1'b0;
        ram_side = 1'b0;
        apply_rom_mask = 1'b1;
        case (area)
            area_ram: begin
                // self flash maps the ram window onto psram
                rom_bank = cfg.ram_bank[8:0];
                rom_side = cfg.self_flash;
                ram_side = ~cfg.self_flash;
                apply_rom_mask = cfg.apply_ram;
            end
            area_rom0: begin
                rom_bank = cfg.rom0_bank[8:0];
                rom_side = 1'b1;
                apply_rom_mask = cfg.apply_rom0;
            end
            area_rom1: begin
                rom_bank = cfg.rom1_bank[8:0];
                rom_side = 1'b1;
                apply_rom_mask = cfg.apply_rom1;
            end
            area_linear: begin
                rom_bank = {cfg.linear_off[4:0], addr_hi};
                rom_side = 1'b1;
            end
            default: begin
            end
        endcase
    end

    assign rom_masked = apply_rom_mask ? (rom_bank & cfg.rom_mask) : rom_bank;
    assign ram_masked = cfg.apply_ram ? (cfg.ram_bank[3:0] & cfg.ram_mask)
                                      : cfg.ram_bank[3:0];

    // bits 8:7 split rom space between the two psram chips
    assign psram1_hit = rom_side & (rom_masked[8:7] == 2'd0);
    assign psram2_hit = rom_side & (rom_masked[8:7] == 2'd1);
    // upper half of ram banks has no sram behind it
    assign sram_hit = ram_side & ~ram_masked[3] & cfg.sram_enable;

    // memory cycle on the cartridge bus
    assign mem_access = ~n_sel & n_io;

    assign n_psram1_sel = ~(mem_access & psram1_hit);
    assign n_psram2_sel = ~(mem_access & psram2_hit);
    assign n_sram_sel = ~(mem_access & sram_hit);

    // sram only decodes the low three bank bits
    assign addr_ext[2:0] = rom_side ? rom_masked[2:0] : ram_masked[2:0];
    assign addr_ext[6:3] = rom_masked[6:3];

    // 8-bit ram window mapped onto one lane of the 16-bit psram
    assign psram_n_lb = (area == area_ram) & addr_lsb;
    assign psram_n_ub = (area == area_ram) & ~addr_lsb;

endmodule

// ==== hw/nileswan_mapper.sv ====
`timescale 1ns/1ps

module nileswan_mapper
    import mapper_pkg::*;
(
    input  logic nWE,
    input  logic reset,
    input  logic n_sel,
    input  logic n_io,
    input  logic n_oe,
    input  logic [8:0] addr_lo,
    input  logic [3:0] addr_hi,
    input  logic [15:0] data,
    output byte_t data_out,
    output logic data_oe,
    output ext_addr_t addr_ext,
    output logic n_psram1_sel,
    output logic n_psram2_sel,
    output logic n_sram_sel,
    output logic psram_n_lb,
    output logic psram_n_ub
);

    // bank configuration shared by register file and decoder
    bank_cfg_if cfg_bus ();

    // i/o registers decode addr_hi with the low address nibble
    bank_regs i_bank_regs (
        .nWE      (nWE),
        .reset    (reset),
        .n_sel    (n_sel),
        .n_io     (n_io),
        .n_oe     (n_oe),
        .io_addr  ({addr_hi, addr_lo[3:0]}),
        .wdata    (data[7:0]),
        .data_out (data_out),
        .data_oe  (data_oe),
        .cfg      (cfg_bus.regs)
    );

    bank_map i_bank_map (
        .n_sel        (n_sel),
        .n_io         (n_io),
        .addr_hi      (addr_hi),
        .addr_lsb     (addr_lo[0]),
        .cfg          (cfg_bus.map),
        .addr_ext     (addr_ext),
        .n_psram1_sel (n_psram1_sel),
        .n_psram2_sel (n_psram2_sel),
        .n_sram_sel   (n_sram_sel),
        .psram_n_lb   (psram_n_lb),
        .psram_n_ub   (psram_n_ub)
    );

endmodule

// ==== sim/nileswan_mapper_assert.sv ====
`timescale 1ns/1ps

module nileswan_mapper_assert (
    input logic nWE,
    input logic reset,
    input logic n_sel,
    input logic n_io,
    input logic n_oe,
    input logic data_oe,
    input logic n_psram1_sel,
    input logic n_psram2_sel,
    input logic n_sram_sel
);

    logic [2:0] sel_active;
    int fail_count = 0;

    assign sel_active = {~n_psram1_sel, ~n_psram2_sel, ~n_sram_sel};

    // only one memory chip may drive the bus
    one_chip_sel: assert property (@(posedge nWE) disable iff (reset)
        $countones(sel_active) <= 1)
        else begin
            fail_count++;
            $error("several chip selects low at once: %b", sel_active);
        end

    // register readback only during an i/o read cycle
    oe_on_io_read: assert property (@(posedge nWE) disable iff (reset)
        data_oe |-> (!n_io && !n_oe))
        else begin
            fail_count++;
            $error("data_oe high outside an i/o read");
        end

    // i/o cycles never reach memory
    no_sel_on_io: assert property (@(posedge nWE) disable iff (reset)
        !n_io |-> (sel_active == 3'b000))
        else begin
            fail_count++;
            $error("chip select low during an i/o cycle");
        end

    no_sel_idle: assert property (@(posedge nWE) disable iff (reset)
        n_sel |-> (sel_active == 3'b000))
        else begin
            fail_count++;
            $error("chip select low while the cartridge is not selected");
        end

endmodule

bind nileswan_mapper nileswan_mapper_assert i_mapper_assert (
    .nWE          (nWE),
    .reset        (reset),
    .n_sel        (n_sel),
    .n_io         (n_io),
    .n_oe         (n_oe),
    .data_oe      (data_oe),
    .n_psram1_sel (n_psram1_sel),
    .n_psram2_sel (n_psram2_sel),
    .n_sram_sel   (n_sram_sel)
);

// ==== sim/tb_nileswan_mapper.sv ====
`timescale 1ns/1ps

module tb_nileswan_mapper
    import mapper_pkg::*;
    import reg_map_pkg::*;
();

    typedef struct packed {
        logic do_write;
        io_addr_t waddr;
        byte_t wdata;
        io_addr_t raddr;
        logic rd_n_io;
        logic exp_oe;
        byte_t exp_data;
    } reg_entry_t;

    typedef struct packed {
        bank_t ram_bank;
        bank_t rom0_bank;
        bank_t rom1_bank;
        linear_t linear_off;
        logic self_flash;
        byte_t mask_lo;
        byte_t mask_hi;
        byte_t pow;
    } cfg_t;

    typedef struct packed {
        logic [3:0] cfg_idx;
        logic [3:0] addr_hi;
        logic addr_lsb;
        ext_addr_t exp_ext;
        logic exp_psram1;
        logic exp_psram2;
        logic exp_sram;
        logic exp_lb;
        logic exp_ub;
    } dec_entry_t;

    localparam time half_period = 10ns;
    localparam int cfg_count = 6;
    // register writes needed to load one decode configuration
    localparam int cfg_writes = 11;

    logic nWE;
    logic reset;
    logic n_sel;
    logic n_io;
    logic n_oe;
    logic [8:0] addr_lo;
    logic [3:0] addr_hi;
    logic [15:0] data;
    byte_t data_out;
    logic data_oe;
    ext_addr_t addr_ext;
    logic n_psram1_sel;
    logic n_psram2_sel;
    logic n_sram_sel;
    logic psram_n_lb;
    logic psram_n_ub;

    reg_entry_t reg_tab[$];
    dec_entry_t dec_tab[$];
    cfg_t cfg_tab[cfg_count];
    logic [31:0] rand_state = 32'hfbaf;
    logic tables_ready = 1'b0;
    int checks = 0;
    int errors = 0;
    int assert_fails = 0;
    int watchdog_cycles;

    nileswan_mapper i_dut (
        .nWE          (nWE),
        .reset        (reset),
        .n_sel        (n_sel),
        .n_io         (n_io),
        .n_oe         (n_oe),
        .addr_lo      (addr_lo),
        .addr_hi      (addr_hi),
        .data         (data),
        .data_out     (data_out),
        .data_oe      (data_oe),
        .addr_ext     (addr_ext),
        .n_psram1_sel (n_psram1_sel),
        .n_psram2_sel (n_psram2_sel),
        .n_sram_sel   (n_sram_sel),
        .psram_n_lb   (psram_n_lb),
        .psram_n_ub   (psram_n_ub)
    );

    always #(half_period) nWE = ~nWE;

    // linear congruential generator, upper bits are the useful ones
    function automatic logic [31:0] rand32();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state >> 12;
    endfunction

    function automatic reg_entry_t make_entry(input logic wr, input io_addr_t waddr,
                                              input byte_t wdata, input io_addr_t raddr,
                                              input logic rd_n_io, input logic exp_oe,
                                              input byte_t exp_data);
        return '{wr, waddr, wdata, raddr, rd_n_io, exp_oe, exp_data};
    endfunction

    // expected memory decode for one window, straight from the mapping rules
    function automatic dec_entry_t expect_decode(input cfg_t c, input logic [3:0] hi,
                                                 input logic lsb);
        dec_entry_t e;
        logic [8:0] bank;
        logic [8:0] bank_m;
        logic [3:0] ram_m;
        logic use_mask;
        logic to_rom;
        logic to_ram;
        e = '0;
        e.addr_hi = hi;
        e.addr_lsb = lsb;
        bank = '0;
        use_mask = 1'b1;
        to_rom = (hi >= 4'h2);
        to_ram = 1'b0;
        if (hi == 4'h1) begin
            bank = c.ram_bank[8:0];
            use_mask = c.mask_hi[3];
            to_rom = c.self_flash;
            to_ram = ~c.self_flash;
        end else if (hi == 4'h2) begin
            bank = c.rom0_bank[8:0];
            use_mask = c.mask_hi[1];
        end else if (hi == 4'h3) begin
            bank = c.rom1_bank[8:0];
            use_mask = c.mask_hi[2];
        end else if (hi >= 4'h4) begin
            bank = {c.linear_off[4:0], hi};
        end
        bank_m = use_mask ? (bank & {c.mask_hi[0], c.mask_lo}) : bank;
        ram_m = c.mask_hi[3] ? (c.ram_bank[3:0] & c.mask_hi[7:4]) : c.ram_bank[3:0];
        e.exp_psram1 = ~(to_rom && bank_m[8:7] == 2'd0);
        e.exp_psram2 = ~(to_rom && bank_m[8:7] == 2'd1);
        e.exp_sram = ~(to_ram && !ram_m[3] && c.pow[6]);
        e.exp_ext = {bank_m[6:3], (to_rom ? bank_m[2:0] : ram_m[2:0])};
        e.exp_lb = (hi == 4'h1) ? lsb : 1'b0;
        e.exp_ub = (hi == 4'h1) ? ~lsb : 1'b0;
        return e;
    endfunction

    task automatic build_tables();
        io_addr_t reg_2001[3];
        io_addr_t reg_2003_l[3];
        io_addr_t reg_2003_h[3];
        byte_t w;
        dec_entry_t e;
        reg_2001 = '{reg_ram_bank, reg_rom_bank_0, reg_rom_bank_1};
        reg_2003_l = '{reg_ram_bank_l, reg_rom_bank_0_l, reg_rom_bank_1_l};
        reg_2003_h = '{reg_ram_bank_h, reg_rom_bank_0_h, reg_rom_bank_1_h};
        // reset values of every kept register
        reg_tab.push_back(make_entry(0, 0, 0, reg_linear_off, 0, 1, 8'hFF));
        for (int i = 0; i < 3; i++) begin
            reg_tab.push_back(make_entry(0, 0, 0, reg_2001[i], 0, 1, 8'hFF));
            reg_tab.push_back(make_entry(0, 0, 0, reg_2003_l[i], 0, 1, 8'hFF));
            reg_tab.push_back(make_entry(0, 0, 0, reg_2003_h[i], 0, 1, 8'h03));
        end
        reg_tab.push_back(make_entry(0, 0, 0, reg_mem_ctrl, 0, 1, 8'h00));
        reg_tab.push_back(make_entry(0, 0, 0, reg_pow_cnt, 0, 1, 8'h5C));
        reg_tab.push_back(make_entry(0, 0, 0, reg_bank_mask_lo, 0, 1, 8'hFF));
        reg_tab.push_back(make_entry(0, 0, 0, reg_bank_mask_hi, 0, 1, 8'hFF));
        // the two layouts share the low bank byte
        for (int i = 0; i < 6; i++) begin
            w = rand32();
            if (i < 3) begin
                reg_tab.push_back(make_entry(1, reg_2001[i], w, reg_2003_l[i], 0, 1, w));
            end else begin
                reg_tab.push_back(make_entry(1, reg_2003_l[i - 3], w, reg_2001[i - 3], 0, 1, w));
            end
        end
        for (int i = 0; i < 3; i++) begin
            w = rand32();
            reg_tab.push_back(make_entry(1, reg_2003_h[i], w, reg_2003_h[i], 0, 1,
                                         {6'b0, w[1:0]}));
        end
        w = rand32();
        reg_tab.push_back(make_entry(1, reg_linear_off, w, reg_linear_off, 0, 1, w));
        w = rand32();
        reg_tab.push_back(make_entry(1, reg_mem_ctrl, w, reg_mem_ctrl, 0, 1, {7'b0, w[0]}));
        w = rand32();
        reg_tab.push_back(make_entry(1, reg_bank_mask_lo, w, reg_bank_mask_lo, 0, 1, w));
        w = rand32();
        reg_tab.push_back(make_entry(1, reg_bank_mask_hi, w, reg_bank_mask_hi, 0, 1, w));
        w = rand32();
        reg_tab.push_back(make_entry(1, reg_pow_cnt, w, reg_pow_cnt, 0, 1,
                                     8'h1C | {1'b0, w[6], 6'b0}));
        // unused addresses and memory cycles never drive the bus
        reg_tab.push_back(make_entry(0, 0, 0, 8'hC4, 0, 0, 0));
        reg_tab.push_back(make_entry(0, 0, 0, 8'hCF, 0, 0, 0));
        reg_tab.push_back(make_entry(0, 0, 0, 8'hE3, 0, 0, 0));
        reg_tab.push_back(make_entry(0, 0, 0, 8'h00, 0, 0, 0));
        reg_tab.push_back(make_entry(0, 0, 0, reg_linear_off, 1, 0, 0));

        for (int i = 0; i < cfg_count; i++) begin
            cfg_tab[i] = '{rand32(), rand32(), rand32(), rand32(), 1'b0, 8'hFF, 8'hFF, 8'h40};
        end
        cfg_tab[0].ram_bank[3] = 1'b0;
        // mask on rom0 and ram only, then on rom1 only
        cfg_tab[2].mask_lo = rand32();
        w = rand32();
        cfg_tab[2].mask_hi = {w[7:4], 3'b101, w[0]};
        cfg_tab[3].mask_lo = rand32();
        w = rand32();
        cfg_tab[3].mask_hi = {w[7:4], 3'b010, w[0]};
        // ram bank in the lower psram half so self flash must pull a psram select
        cfg_tab[4].self_flash = 1'b1;
        cfg_tab[4].ram_bank[8] = 1'b0;
        cfg_tab[5].pow = 8'h00;
        cfg_tab[5].ram_bank[3] = 1'b0;
        for (int i = 0; i < cfg_count; i++) begin
            for (int hi = 0; hi < 16; hi++) begin
                w = rand32();
                e = expect_decode(cfg_tab[i], hi, w[5]);
                e.cfg_idx = i;
                dec_tab.push_back(e);
            end
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("ERR %s got %0h expected %0h", name, got, exp);
        end
    endtask

    task automatic io_write(input io_addr_t addr, input byte_t value);
        @(negedge nWE);
        n_sel = 1'b0;
        n_io = 1'b0;
        n_oe = 1'b1;
        addr_hi = addr[7:4];
        addr_lo = {5'b0, addr[3:0]};
        data = {8'h00, value};
        @(posedge nWE);
    endtask

    task automatic io_read_check(input io_addr_t addr, input logic io_high,
                                 input logic exp_oe, input byte_t exp_data);
        @(negedge nWE);
        n_sel = 1'b0;
        n_io = io_high;
        n_oe = 1'b0;
        addr_hi = addr[7:4];
        addr_lo = {5'b0, addr[3:0]};
        @(posedge nWE);
        check_value("data_oe", data_oe, exp_oe);
        if (exp_oe) begin
            check_value("data_out", data_out, exp_data);
        end
    endtask

    task automatic load_cfg(input cfg_t c);
        io_write(reg_linear_off, c.linear_off);
        io_write(reg_ram_bank_l, c.ram_bank[7:0]);
        io_write(reg_ram_bank_h, {6'b0, c.ram_bank[9:8]});
        io_write(reg_rom_bank_0_l, c.rom0_bank[7:0]);
        io_write(reg_rom_bank_0_h, {6'b0, c.rom0_bank[9:8]});
        io_write(reg_rom_bank_1_l, c.rom1_bank[7:0]);
        io_write(reg_rom_bank_1_h, {6'b0, c.rom1_bank[9:8]});
        io_write(reg_mem_ctrl, {7'b0, c.self_flash});
        io_write(reg_bank_mask_lo, c.mask_lo);
        io_write(reg_bank_mask_hi, c.mask_hi);
        io_write(reg_pow_cnt, c.pow);
    endtask

    task automatic run_tables();
        logic [3:0] loaded;
        loaded = 4'hF;
        foreach (reg_tab[i]) begin
            if (reg_tab[i].do_write) begin
                io_write(reg_tab[i].waddr, reg_tab[i].wdata);
            end
            io_read_check(reg_tab[i].raddr, reg_tab[i].rd_n_io, reg_tab[i].exp_oe,
                          reg_tab[i].exp_data);
        end
        foreach (dec_tab[i]) begin
            if (dec_tab[i].cfg_idx != loaded) begin
                loaded = dec_tab[i].cfg_idx;
                load_cfg(cfg_tab[loaded]);
            end
            @(negedge nWE);
            n_sel = 1'b0;
            n_io = 1'b1;
            n_oe = 1'b0;
            addr_hi = dec_tab[i].addr_hi;
            addr_lo = {8'h00, dec_tab[i].addr_lsb};
            @(posedge nWE);
            check_value("addr_ext", addr_ext, dec_tab[i].exp_ext);
            check_value("n_psram1_sel", n_psram1_sel, dec_tab[i].exp_psram1);
            check_value("n_psram2_sel", n_psram2_sel, dec_tab[i].exp_psram2);
            check_value("n_sram_sel", n_sram_sel, dec_tab[i].exp_sram);
            check_value("psram_n_lb", psram_n_lb, dec_tab[i].exp_lb);
            check_value("psram_n_ub", psram_n_ub, dec_tab[i].exp_ub);
        end
    endtask

    initial begin
        nWE = 1'b0;
        reset = 1'b1;
        n_sel = 1'b1;
        n_io = 1'b1;
        n_oe = 1'b1;
        addr_lo = '0;
        addr_hi = '0;
        data = '0;
        build_tables();
        tables_ready = 1'b1;
        repeat (10) @(posedge nWE);
        @(negedge nWE);
        reset = 1'b0;
        run_tables();
        @(negedge nWE);
        n_sel = 1'b1;
        n_io = 1'b1;
        n_oe = 1'b1;
        @(posedge nWE);
        @(negedge nWE);
        assert_fails = i_dut.i_mapper_assert.fail_count;
        $display("checks %0d errors %0d assertion failures %0d", checks, errors,
                 assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // every table entry and config write gets four cycles of headroom
    initial begin
        wait (tables_ready);
        watchdog_cycles = (reg_tab.size() + dec_tab.size() + cfg_count * cfg_writes) * 4 + 50;
        repeat (watchdog_cycles) @(posedge nWE);
        $display("watchdog expired after %0d cycles, the tests did not complete",
                 watchdog_cycles);
        $display("TEST FAILED");
        $finish;
    end

endmodule

// ==== compile.f ====
hw/mapper_pkg.sv
hw/reg_map_pkg.sv
hw/bank_cfg_if.sv
hw/bank_regs.sv
hw/bank_map.sv
hw/nileswan_mapper.sv
sim/nileswan_mapper_assert.sv
sim/tb_nileswan_mapper.sv
